// File: source/rv_pkg.sv
package rv_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_BRANCH = 7'b1100011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_IMM    = 7'b0010011,
        OP_OP     = 7'b0110011
    } opcode_e;

    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            reg_addr_t  rs2;
            reg_addr_t  rs1;
            logic [2:0] funct3;
            reg_addr_t  rd;
            logic [6:0] opcode;
        } r_fmt;
        struct packed {
            logic [11:0] imm_11_0;
            reg_addr_t   rs1;
            logic [2:0]  funct3;
            reg_addr_t   rd;
            logic [6:0]  opcode;
        } i_fmt;
        struct packed {
            logic [6:0] imm_11_5;
            reg_addr_t  rs2;
            reg_addr_t  rs1;
            logic [2:0] funct3;
            logic [4:0] imm_4_0;
            logic [6:0] opcode;
        } s_fmt;
        struct packed {
            logic       imm_12;
            logic [5:0] imm_10_5;
            reg_addr_t  rs2;
            reg_addr_t  rs1;
            logic [2:0] funct3;
            logic [3:0] imm_4_1;
            logic       imm_11;
            logic [6:0] opcode;
        } b_fmt;
        struct packed {
            logic [19:0] imm_31_12;
            reg_addr_t   rd;
            logic [6:0]  opcode;
        } u_fmt;
        struct packed {
            logic       imm_20;
            logic [9:0] imm_10_1;
            logic       imm_11;
            logic [7:0] imm_19_12;
            reg_addr_t  rd;
            logic [6:0] opcode;
        } j_fmt;
    } instr_u;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU,
        ALU_PASS_B,
        ALU_PC_ADD
    } alu_op_e;

    typedef struct packed {
        alu_op_e    alu_op;
        logic       use_imm;    // operand b comes from imm
        logic       is_load;
        logic       is_store;
        logic       is_byte_store;
        logic       is_branch;
        logic [2:0] branch_f3;
        logic       is_jal;
        logic       is_jalr;
        logic       writes_rd;
    } ctrl_t;

    typedef struct packed {
        ctrl_t     ctrl;
        word_t     pc;
        word_t     a;
        word_t     b;
        word_t     imm;
        reg_addr_t rd;
    } de_ex_t;

    typedef struct packed {
        logic [XLEN-3:0] addr;  // word address
        logic [3:0]      byte_en;
        word_t           store_data;
        logic            is_load;
    } mem_req_t;

    typedef struct packed {
        logic  taken;
        word_t target;
    } jump_t;

endpackage

// File: source/rv_fetch.sv
`timescale 1ns/1ps

module rv_fetch #(
    parameter int IMEM_WORDS = 256
) (
    input  logic                          clk,
    input  logic                          reset,
    input  rv_pkg::jump_t                 i_jump,
    input  logic                          i_prog_we,
    input  logic [$clog2(IMEM_WORDS)-1:0] i_prog_addr,
    input  rv_pkg::word_t                 i_prog_data,
    output rv_pkg::word_t                 o_pc,
    output rv_pkg::instr_u                o_inst
);
    import rv_pkg::*;

    localparam int ADDR_W = $clog2(IMEM_WORDS);

    word_t imem [IMEM_WORDS];

    always_ff @(posedge clk) begin
        if (reset) begin
            o_pc <= '0;
        end else if (i_jump.taken) begin
            o_pc <= i_jump.target;
        end else begin
            o_pc <= o_pc + 32'd4;
        end
    end

    // program load only while the core is held in reset
    always_ff @(posedge clk) begin
        if (reset && i_prog_we) begin
            imem[i_prog_addr] <= i_prog_data;
        end
    end

    assign o_inst = instr_u'(imem[o_pc[ADDR_W+1:2]]);  // async read

endmodule

// File: source/rv_decode.sv
`timescale 1ns/1ps

module rv_decode (
    input  logic              clk,
    input  logic              reset,
    input  rv_pkg::word_t     i_pc,
    input  rv_pkg::instr_u    i_inst,
    input  rv_pkg::jump_t     i_jump,
    input  rv_pkg::word_t     i_rs1_val,
    input  rv_pkg::word_t     i_rs2_val,
    output rv_pkg::reg_addr_t o_rs1,
    output rv_pkg::reg_addr_t o_rs2,
    output rv_pkg::de_ex_t    o_de_ex
);
    import rv_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_u;
    word_t      imm_j;
    logic       shift_f7_ok;
    logic       reg_f7_ok;
    alu_op_e    arith_op;
    ctrl_t      ctrl;
    word_t      imm;

    assign opcode = i_inst.r_fmt.opcode;
    assign funct3 = i_inst.r_fmt.funct3;
    assign funct7 = i_inst.r_fmt.funct7;
    assign o_rs1  = i_inst.r_fmt.rs1;
    assign o_rs2  = i_inst.r_fmt.rs2;

    assign imm_i = {{20{i_inst.i_fmt.imm_11_0[11]}}, i_inst.i_fmt.imm_11_0};
    assign imm_s = {{20{i_inst.s_fmt.imm_11_5[6]}}, i_inst.s_fmt.imm_11_5,
                    i_inst.s_fmt.imm_4_0};
    assign imm_b = {{19{i_inst.b_fmt.imm_12}}, i_inst.b_fmt.imm_12, i_inst.b_fmt.imm_11,
                    i_inst.b_fmt.imm_10_5, i_inst.b_fmt.imm_4_1, 1'b0};
    assign imm_u = {i_inst.u_fmt.imm_31_12, 12'h000};
    assign imm_j = {{11{i_inst.j_fmt.imm_20}}, i_inst.j_fmt.imm_20, i_inst.j_fmt.imm_19_12,
                    i_inst.j_fmt.imm_11, i_inst.j_fmt.imm_10_1, 1'b0};

    // funct7 may only be 0x20 for sub and the arithmetic shift
    assign shift_f7_ok = (funct7 == 7'h00) || (funct7 == 7'h20 && funct3 == 3'b101);
    assign reg_f7_ok   = (funct7 == 7'h00) ||
                         (funct7 == 7'h20 && (funct3 == 3'b000 || funct3 == 3'b101));

    always_comb begin
        case (funct3)
            3'b000:  arith_op = (opcode == OP_OP && funct7[5]) ? ALU_SUB : ALU_ADD;
            3'b001:  arith_op = ALU_SLL;
            3'b010:  arith_op = ALU_SLT;
            3'b011:  arith_op = ALU_SLTU;
            3'b100:  arith_op = ALU_XOR;
            3'b101:  arith_op = funct7[5] ? ALU_SRA : ALU_SRL;
            3'b110:  arith_op = ALU_OR;
            default: arith_op = ALU_AND;
        endcase
    end

    always_comb begin
        ctrl = '0;  // anything not matched below becomes a bubble
        imm  = '0;
        case (opcode)
            OP_LUI: begin
                ctrl.alu_op    = ALU_PASS_B;
                ctrl.use_imm   = 1'b1;
                ctrl.writes_rd = 1'b1;
                imm            = imm_u;
            end
            OP_AUIPC: begin
                ctrl.alu_op    = ALU_PC_ADD;
                ctrl.use_imm   = 1'b1;
                ctrl.writes_rd = 1'b1;
                imm            = imm_u;
            end
            OP_JAL: begin
                ctrl.is_jal    = 1'b1;
                ctrl.writes_rd = 1'b1;
                imm            = imm_j;
            end
            OP_JALR: begin
                if (funct3 == 3'b000) begin
                    ctrl.is_jalr   = 1'b1;
                    ctrl.use_imm   = 1'b1;  // alu forms rs1 + imm
                    ctrl.writes_rd = 1'b1;
                    imm            = imm_i;
                end
            end
            OP_BRANCH: begin
                if (funct3[2:1] != 2'b01) begin
                    ctrl.is_branch = 1'b1;
                    ctrl.branch_f3 = funct3;
                    imm            = imm_b;
                end
            end
            OP_LOAD: begin
                if (funct3 == 3'b010) begin
                    ctrl.is_load   = 1'b1;
                    ctrl.use_imm   = 1'b1;
                    ctrl.writes_rd = 1'b1;
                    imm            = imm_i;
                end
            end
            OP_STORE: begin
                if (funct3 == 3'b000 || funct3 == 3'b010) begin
                    ctrl.is_store      = 1'b1;
                    ctrl.is_byte_store = (funct3 == 3'b000);
                    ctrl.use_imm       = 1'b1;
                    imm                = imm_s;
                end
            end
            OP_IMM: begin
                if (funct3[1:0] != 2'b01 || shift_f7_ok) begin
                    ctrl.alu_op    = arith_op;
                    ctrl.use_imm   = 1'b1;
                    ctrl.writes_rd = 1'b1;
                    imm            = imm_i;  // shamt sits in the low 5 bits
                end
            end
            OP_OP: begin
                if (reg_f7_ok) begin
                    ctrl.alu_op    = arith_op;
                    ctrl.writes_rd = 1'b1;
                end
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset || i_jump.taken) begin
            o_de_ex.ctrl <= '0;  // squash wrong-path instr
        end else begin
            o_de_ex.ctrl <= ctrl;
        end
        o_de_ex.pc  <= i_pc;
        o_de_ex.a   <= i_rs1_val;
        o_de_ex.b   <= i_rs2_val;
        o_de_ex.imm <= imm;
        o_de_ex.rd  <= i_inst.r_fmt.rd;
    end

endmodule

// File: source/rv_regfile.sv
`timescale 1ns/1ps

module rv_regfile (
    input  logic              clk,
    input  rv_pkg::reg_addr_t i_rs1,
    input  rv_pkg::reg_addr_t i_rs2,
    input  logic              i_we,
    input  rv_pkg::reg_addr_t i_rd,
    input  rv_pkg::word_t     i_wdata,
    output rv_pkg::word_t     o_rs1_val,
    output rv_pkg::word_t     o_rs2_val
);
    import rv_pkg::*;

    word_t regs [1:31];  // x0 not stored

    always_ff @(posedge clk) begin
        if (i_we && i_rd != '0) begin
            regs[i_rd] <= i_wdata;
        end
    end

    // pending write-back bypasses the array
    function automatic word_t read_port(reg_addr_t addr);
        if (addr == '0) begin
            return '0;
        end else if (i_we && addr == i_rd) begin
            return i_wdata;
        end else begin
            return regs[addr];
        end
    endfunction

    assign o_rs1_val = read_port(i_rs1);
    assign o_rs2_val = read_port(i_rs2);

endmodule

// File: source/rv_execute.sv
`timescale 1ns/1ps

module rv_execute (
    input  rv_pkg::de_ex_t    i_de_ex,
    input  rv_pkg::word_t     i_load_data,
    output rv_pkg::mem_req_t  o_mem_req,
    output rv_pkg::jump_t     o_jump,
    output logic              o_wb_en,
    output rv_pkg::reg_addr_t o_wb_rd,
    output rv_pkg::word_t     o_wb_data
);
    import rv_pkg::*;

    ctrl_t ctrl;
    word_t a;
    word_t b;
    word_t op_b;
    word_t alu_res;
    word_t link;
    logic  br_cond;

    assign ctrl = i_de_ex.ctrl;
    assign a    = i_de_ex.a;
    assign b    = i_de_ex.b;
    assign op_b = ctrl.use_imm ? i_de_ex.imm : b;
    assign link = i_de_ex.pc + 32'd4;

    always_comb begin
        case (ctrl.alu_op)
            ALU_ADD:    alu_res = a + op_b;
            ALU_SUB:    alu_res = a - op_b;
            ALU_AND:    alu_res = a & op_b;
            ALU_OR:     alu_res = a | op_b;
            ALU_XOR:    alu_res = a ^ op_b;
            ALU_SLL:    alu_res = a << op_b[4:0];
            ALU_SRL:    alu_res = a >> op_b[4:0];
            ALU_SRA:    alu_res = $signed(a) >>> op_b[4:0];
            ALU_SLT:    alu_res = {31'b0, $signed(a) < $signed(op_b)};
            ALU_SLTU:   alu_res = {31'b0, a < op_b};
            ALU_PASS_B: alu_res = op_b;             // lui
            ALU_PC_ADD: alu_res = i_de_ex.pc + op_b;  // auipc
            default:    alu_res = '0;
        endcase
    end

    // branch compare always on the two register values
    always_comb begin
        case (ctrl.branch_f3)
            3'b000:  br_cond = (a == b);
            3'b001:  br_cond = (a != b);
            3'b100:  br_cond = ($signed(a) < $signed(b));
            3'b101:  br_cond = ($signed(a) >= $signed(b));
            3'b110:  br_cond = (a < b);
            3'b111:  br_cond = (a >= b);
            default: br_cond = 1'b0;
        endcase
    end

    always_comb begin
        o_jump.taken = ctrl.is_jal || ctrl.is_jalr || (ctrl.is_branch && br_cond);
        if (ctrl.is_jalr) begin
            o_jump.target = {alu_res[31:1], 1'b0};
        end else begin
            o_jump.target = i_de_ex.pc + i_de_ex.imm;
        end
    end

    always_comb begin
        o_mem_req.addr    = alu_res[31:2];
        o_mem_req.is_load = ctrl.is_load;
        if (ctrl.is_byte_store) begin
            o_mem_req.byte_en    = 4'b0001 << alu_res[1:0];
            o_mem_req.store_data = {4{b[7:0]}};  // byte in every lane
        end else begin
            o_mem_req.byte_en    = ctrl.is_store ? 4'b1111 : 4'b0000;
            o_mem_req.store_data = b;
        end
    end

    assign o_wb_en = ctrl.writes_rd;
    assign o_wb_rd = i_de_ex.rd;

    always_comb begin
        if (ctrl.is_load) begin
            o_wb_data = i_load_data;
        end else if (ctrl.is_jal || ctrl.is_jalr) begin
            o_wb_data = link;
        end else begin
            o_wb_data = alu_res;
        end
    end

endmodule

// File: source/rv_dmem.sv
`timescale 1ns/1ps

module rv_dmem #(
    parameter int            DMEM_WORDS   = 256,
    parameter rv_pkg::word_t UART_TX_ADDR = 32'h0002_0020
) (
    input  logic             clk,
    input  logic             reset,
    input  rv_pkg::mem_req_t i_req,
    output rv_pkg::word_t    o_load_data,
    output logic             o_uart_valid,
    output logic [7:0]       o_uart_data
);
    import rv_pkg::*;

    localparam int IDX_W     = $clog2(DMEM_WORDS);
    localparam int UART_LANE = int'(UART_TX_ADDR[1:0]);

    word_t             dmem [DMEM_WORDS];
    logic [IDX_W-1:0]  idx;
    logic              uart_hit;

    assign idx = i_req.addr[IDX_W-1:0];  // upper bits alias

    // single-lane store to the tx byte
    assign uart_hit = (i_req.addr == UART_TX_ADDR[XLEN-1:2]) &&
                      (i_req.byte_en == (4'b0001 << UART_LANE));

    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (i_req.byte_en[i]) begin
                dmem[idx][i*8 +: 8] <= i_req.store_data[i*8 +: 8];
            end
        end
    end

    assign o_load_data = i_req.is_load ? dmem[idx] : '0;

    always_ff @(posedge clk) begin
        if (reset) begin
            o_uart_valid <= 1'b0;
        end else begin
            o_uart_valid <= uart_hit;
        end
        if (uart_hit) begin
            o_uart_data <= i_req.store_data[UART_LANE*8 +: 8];
        end
    end

endmodule

// File: source/rv_core.sv
`timescale 1ns/1ps

module rv_core #(
    parameter int            IMEM_WORDS   = 256,
    parameter int            DMEM_WORDS   = 256,
    parameter rv_pkg::word_t UART_TX_ADDR = 32'h0002_0020
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          i_prog_we,
    input  logic [$clog2(IMEM_WORDS)-1:0] i_prog_addr,
    input  rv_pkg::word_t                 i_prog_data,
    output logic                          o_uart_valid,
    output logic [7:0]                    o_uart_data
);
    import rv_pkg::*;

    word_t     pc;
    instr_u    inst;
    jump_t     jump;
    reg_addr_t rs1;
    reg_addr_t rs2;
    word_t     rs1_val;
    word_t     rs2_val;
    de_ex_t    de_ex;
    mem_req_t  mem_req;
    word_t     load_data;
    logic      wb_en;
    reg_addr_t wb_rd;
    word_t     wb_data;

    rv_fetch #(
        .IMEM_WORDS (IMEM_WORDS)
    ) i_rv_fetch (
        .clk         (clk),
        .reset       (reset),
        .i_jump      (jump),
        .i_prog_we   (i_prog_we),
        .i_prog_addr (i_prog_addr),
        .i_prog_data (i_prog_data),
        .o_pc        (pc),
        .o_inst      (inst)
    );

    rv_decode i_rv_decode (
        .clk       (clk),
        .reset     (reset),
        .i_pc      (pc),
        .i_inst    (inst),
        .i_jump    (jump),
        .i_rs1_val (rs1_val),
        .i_rs2_val (rs2_val),
        .o_rs1     (rs1),
        .o_rs2     (rs2),
        .o_de_ex   (de_ex)
    );

    rv_regfile i_rv_regfile (
        .clk       (clk),
        .i_rs1     (rs1),
        .i_rs2     (rs2),
        .i_we      (wb_en),
        .i_rd      (wb_rd),
        .i_wdata   (wb_data),
        .o_rs1_val (rs1_val),
        .o_rs2_val (rs2_val)
    );

    rv_execute i_rv_execute (
        .i_de_ex     (de_ex),
        .i_load_data (load_data),
        .o_mem_req   (mem_req),
        .o_jump      (jump),
        .o_wb_en     (wb_en),
        .o_wb_rd     (wb_rd),
        .o_wb_data   (wb_data)
    );

    rv_dmem #(
        .DMEM_WORDS   (DMEM_WORDS),
        .UART_TX_ADDR (UART_TX_ADDR)
    ) i_rv_dmem (
        .clk          (clk),
        .reset        (reset),
        .i_req        (mem_req),
        .o_load_data  (load_data),
        .o_uart_valid (o_uart_valid),
        .o_uart_data  (o_uart_data)
    );

endmodule

// File: tb/rv_checker.sv
`timescale 1ns/1ps

module rv_checker #(
    parameter int          IMEM_WORDS   = 256,
    parameter logic [31:0] UART_TX_ADDR = 32'h0002_0020
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          i_prog_we,
    input  logic [$clog2(IMEM_WORDS)-1:0] i_prog_addr,
    input  logic [31:0]                   i_prog_data,
    input  logic                          i_uart_valid,
    input  logic [7:0]                    i_uart_data,
    output logic                          o_ready,
    output logic                          o_done,
    output int                            o_bound,
    output int                            o_mismatches,
    output int                            o_extras,
    output int                            o_missing
);
    localparam int ADDR_W = $clog2(IMEM_WORDS);

    logic [31:0] image [IMEM_WORDS];
    logic [7:0]  exp_q [$];
    int          exp_count;
    int          rx_count;

    assign o_done    = o_ready && (rx_count >= exp_count);
    assign o_missing = exp_count - rx_count;

    always @(posedge clk) begin
        if (reset && i_prog_we) begin
            image[i_prog_addr] <= i_prog_data;
        end
    end

    // ISA interpreter over the loaded image up to the jal x0 self-loop
    function automatic int run_reference();
        logic [31:0] regs [32];
        logic [31:0] mem [int];
        logic [31:0] pc;
        logic [31:0] ins;
        logic [31:0] nxt;
        logic [31:0] rs1v;
        logic [31:0] rs2v;
        logic [31:0] opb;
        logic [31:0] res;
        logic [31:0] addr;
        logic [31:0] word;
        logic [31:0] immi;
        logic [31:0] imms;
        logic [31:0] immb;
        logic [31:0] immu;
        logic [31:0] immj;
        logic [4:0]  rd;
        logic [2:0]  f3;
        logic        we;
        logic        cond;
        int          steps;
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        pc    = '0;
        steps = 0;
        exp_q.delete();
        while (steps < 10000) begin
            ins = image[pc[ADDR_W+1:2]];
            if (ins == 32'h0000_006f) begin
                break;
            end
            rd   = ins[11:7];
            f3   = ins[14:12];
            rs1v = regs[ins[19:15]];
            rs2v = regs[ins[24:20]];
            immi = {{20{ins[31]}}, ins[31:20]};
            imms = {{20{ins[31]}}, ins[31:25], ins[11:7]};
            immb = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
            immu = {ins[31:12], 12'h000};
            immj = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
            nxt  = pc + 32'd4;
            we   = 1'b0;
            res  = '0;
            case (ins[6:0])
                7'h37: begin
                    res = immu;
                    we  = 1'b1;
                end
                7'h17: begin
                    res = pc + immu;
                    we  = 1'b1;
                end
                7'h6f: begin
                    res = pc + 32'd4;
                    we  = 1'b1;
                    nxt = pc + immj;
                end
                7'h67: begin
                    res = pc + 32'd4;
                    we  = 1'b1;
                    nxt = (rs1v + immi) & ~32'h1;
                end
                7'h63: begin
                    case (f3)
                        3'd0:    cond = (rs1v == rs2v);
                        3'd1:    cond = (rs1v != rs2v);
                        3'd4:    cond = ($signed(rs1v) < $signed(rs2v));
                        3'd5:    cond = ($signed(rs1v) >= $signed(rs2v));
                        3'd6:    cond = (rs1v < rs2v);
                        3'd7:    cond = (rs1v >= rs2v);
                        default: cond = 1'b0;
                    endcase
                    if (cond) begin
                        nxt = pc + immb;
                    end
                end
                7'h03: begin
                    addr = rs1v + immi;
                    res  = mem.exists(addr[31:2]) ? mem[addr[31:2]] : '0;
                    we   = 1'b1;
                end
                7'h23: begin
                    addr = rs1v + imms;
                    word = mem.exists(addr[31:2]) ? mem[addr[31:2]] : '0;
                    if (f3 == 3'd0) begin
                        word[addr[1:0]*8 +: 8] = rs2v[7:0];
                        if (addr == UART_TX_ADDR) begin
                            exp_q.push_back(rs2v[7:0]);
                        end
                    end else begin
                        word = rs2v;
                    end
                    mem[addr[31:2]] = word;
                end
                7'h13, 7'h33: begin
                    opb = ins[5] ? rs2v : immi;  // bit 5 set for register form
                    case (f3)
                        3'd0: res = (ins[5] && ins[30]) ? rs1v - opb : rs1v + opb;
                        3'd1: res = rs1v << opb[4:0];
                        3'd2: res = {31'b0, $signed(rs1v) < $signed(opb)};
                        3'd3: res = {31'b0, rs1v < opb};
                        3'd4: res = rs1v ^ opb;
                        3'd5: begin
                            if (ins[30]) begin
                                res = $signed(rs1v) >>> opb[4:0];
                            end else begin
                                res = rs1v >> opb[4:0];
                            end
                        end
                        3'd6: res = rs1v | opb;
                        3'd7: res = rs1v & opb;
                    endcase
                    we = 1'b1;
                end
                default: ;
            endcase
            if (we && rd != 5'd0) begin
                regs[rd] = res;
            end
            pc = nxt;
            steps++;
        end
        exp_count = exp_q.size();
        return steps;
    endfunction

    initial begin
        o_ready      = 1'b0;
        o_bound      = 0;
        o_mismatches = 0;
        o_extras     = 0;
        exp_count    = 0;
        rx_count     = 0;
        @(negedge reset);
        o_bound = run_reference();
        o_ready = 1'b1;
    end

    // bytes must arrive in program order
    always @(posedge clk) begin
        if (!reset && i_uart_valid) begin
            if (rx_count < exp_count) begin
                if (i_uart_data !== exp_q[rx_count]) begin
                    $display("** Error: o_uart_data byte %0d expected 0x%02h actual 0x%02h",
                             rx_count, exp_q[rx_count], i_uart_data);
                    o_mismatches++;
                end
                rx_count++;
            end else begin
                $display("unexpected extra UART byte 0x%02h after all %0d expected bytes",
                         i_uart_data, exp_count);
                o_extras++;
            end
        end
    end

endmodule

// File: tb/tb_rv_core.sv
`timescale 1ns/1ps

module tb_rv_core;

    localparam int          IMEM_WORDS   = 256;
    localparam int          DMEM_WORDS   = 256;
    localparam logic [31:0] UART_TX_ADDR = 32'h0002_0020;
    localparam int          CLK_PERIOD   = 40;
    localparam int          RESET_CYCLES = 16;

    localparam logic [6:0] OPC_LUI    = 7'h37;
    localparam logic [6:0] OPC_AUIPC  = 7'h17;
    localparam logic [6:0] OPC_JAL    = 7'h6f;
    localparam logic [6:0] OPC_JALR   = 7'h67;
    localparam logic [6:0] OPC_BRANCH = 7'h63;
    localparam logic [6:0] OPC_LOAD   = 7'h03;
    localparam logic [6:0] OPC_STORE  = 7'h23;
    localparam logic [6:0] OPC_IMM    = 7'h13;
    localparam logic [6:0] OPC_OP     = 7'h33;

    localparam logic [4:0] X_UART = 5'd10;  // holds the tx address
    localparam logic [4:0] X_TMP  = 5'd9;

    logic                          clk;
    logic                          reset;
    logic                          prog_we;
    logic [$clog2(IMEM_WORDS)-1:0] prog_addr;
    logic [31:0]                   prog_data;
    logic                          uart_valid;
    logic [7:0]                    uart_data;
    logic                          chk_ready;
    logic                          chk_done;
    int                            chk_bound;
    int                            chk_mismatches;
    int                            chk_extras;
    int                            chk_missing;
    logic [31:0]                   prog [$];
    logic                          timed_out;
    int                            marker;

    rv_core #(
        .IMEM_WORDS   (IMEM_WORDS),
        .DMEM_WORDS   (DMEM_WORDS),
        .UART_TX_ADDR (UART_TX_ADDR)
    ) i_rv_core (
        .clk          (clk),
        .reset        (reset),
        .i_prog_we    (prog_we),
        .i_prog_addr  (prog_addr),
        .i_prog_data  (prog_data),
        .o_uart_valid (uart_valid),
        .o_uart_data  (uart_data)
    );

    rv_checker #(
        .IMEM_WORDS   (IMEM_WORDS),
        .UART_TX_ADDR (UART_TX_ADDR)
    ) i_rv_checker (
        .clk          (clk),
        .reset        (reset),
        .i_prog_we    (prog_we),
        .i_prog_addr  (prog_addr),
        .i_prog_data  (prog_data),
        .i_uart_valid (uart_valid),
        .i_uart_data  (uart_data),
        .o_ready      (chk_ready),
        .o_done       (chk_done),
        .o_bound      (chk_bound),
        .o_mismatches (chk_mismatches),
        .o_extras     (chk_extras),
        .o_missing    (chk_missing)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                          logic [2:0] f3, logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                          logic [4:0] rd, logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_s(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                          logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
    endfunction

    function automatic logic [31:0] enc_b(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                          logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] enc_u(logic [19:0] imm, logic [4:0] rd, logic [6:0] op);
        return {imm, rd, op};
    endfunction

    function automatic logic [31:0] enc_j(logic [20:0] imm, logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
    endfunction

    task automatic emit(logic [31:0] word);
        prog.push_back(word);
    endtask

    // lui + addi with the upper part rounded up for a negative low half
    task automatic load_const(logic [4:0] rd, logic [31:0] val);
        logic [31:0] hi;
        hi = val + 32'h800;
        emit(enc_u(hi[31:12], rd, OPC_LUI));
        emit(enc_i(val[11:0], rd, 3'd0, rd, OPC_IMM));
    endtask

    task automatic print_reg(logic [4:0] rs);
        emit(enc_s(12'd0, rs, X_UART, 3'd0));
    endtask

    task automatic print_word(logic [4:0] rs);
        print_reg(rs);
        for (int sh = 8; sh < 32; sh += 8) begin
            emit(enc_i(12'(sh), rs, 3'd5, X_TMP, OPC_IMM));
            print_reg(X_TMP);
        end
    endtask

    task automatic build_alu();
        logic [11:0] imm;
        logic [4:0]  sh;
        for (int f = 0; f < 8; f++) begin
            emit(enc_r(7'h00, 5'd2, 5'd1, 3'(f), 5'd3));
            if (f == 1 || f == 5) begin
                print_word(5'd3);  // shifts move bits out of the low byte
            end else begin
                print_reg(5'd3);
            end
        end
        emit(enc_r(7'h20, 5'd2, 5'd1, 3'd0, 5'd3));  // sub
        print_reg(5'd3);
        emit(enc_r(7'h20, 5'd2, 5'd18, 3'd5, 5'd3));  // sra
        print_word(5'd3);
        for (int f = 0; f < 8; f++) begin
            sh  = 5'($urandom);
            imm = (f == 1 || f == 5) ? {7'h00, sh} : 12'($urandom);
            emit(enc_i(imm, 5'd1, 3'(f), 5'd3, OPC_IMM));
            if (f == 1 || f == 5) begin
                print_word(5'd3);
            end else begin
                print_reg(5'd3);
            end
        end
        sh = 5'($urandom);
        emit(enc_i({7'h20, sh}, 5'd18, 3'd5, 5'd3, OPC_IMM));  // srai
        print_word(5'd3);
    endtask

    task automatic build_forward_mem();
        emit(enc_r(7'h00, 5'd2, 5'd1, 3'd0, 5'd4));
        emit(enc_r(7'h20, 5'd1, 5'd4, 3'd0, 5'd5));
        emit(enc_r(7'h00, 5'd4, 5'd5, 3'd4, 5'd6));
        print_reg(5'd6);
        emit(enc_s(12'd16, 5'd6, 5'd0, 3'd2));
        emit(enc_i(12'd16, 5'd0, 3'd2, 5'd7, OPC_LOAD));
        emit(enc_i(12'd1, 5'd7, 3'd0, 5'd8, OPC_IMM));  // load-use
        print_word(5'd8);
        emit(enc_s(12'd20, 5'd2, 5'd0, 3'd2));
        emit(enc_s(12'd21, 5'd1, 5'd0, 3'd0));  // lane 1 only
        emit(enc_i(12'd20, 5'd0, 3'd2, 5'd7, OPC_LOAD));
        print_word(5'd7);
    endtask

    task automatic build_branches();
        logic [2:0] kinds [6];
        logic [4:0] rs_a;
        logic [4:0] rs_b;
        kinds = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
        foreach (kinds[k]) begin
            for (int p = 0; p < 3; p++) begin
                rs_a = (p == 2) ? 5'd2 : 5'd1;
                rs_b = (p == 1) ? 5'd2 : 5'd1;
                marker++;
                emit(enc_i(12'(marker), 5'd0, 3'd0, 5'd11, OPC_IMM));
                emit(enc_b(13'd8, rs_b, rs_a, kinds[k]));
                print_reg(5'd11);  // only on fall-through
                emit(enc_i(12'd128, 5'd11, 3'd0, 5'd11, OPC_IMM));
                print_reg(5'd11);
            end
        end
    endtask

    task automatic build_jumps();
        emit(enc_i(12'h055, 5'd0, 3'd0, 5'd13, OPC_IMM));
        emit(enc_j(21'd8, 5'd12));
        emit(enc_i(12'h077, 5'd0, 3'd0, 5'd13, OPC_IMM));  // squashed wrong-path write
        print_reg(5'd13);
        print_reg(5'd12);
        emit(enc_u(20'd0, 5'd14, OPC_AUIPC));
        emit(enc_i(12'd13, 5'd14, 3'd0, 5'd15, OPC_JALR));  // low bit of the odd offset is cleared
        emit(enc_i(12'h066, 5'd0, 3'd0, 5'd13, OPC_IMM));
        print_reg(5'd13);
        print_reg(5'd15);
        emit(enc_u(20'($urandom), 5'd16, OPC_LUI));
        print_word(5'd16);
        emit(enc_u(20'($urandom), 5'd17, OPC_AUIPC));
        print_word(5'd17);
    endtask

    initial begin
        clk       = 1'b0;
        reset     = 1'b1;
        prog_we   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        timed_out = 1'b0;
        marker    = 0;
        void'($urandom(22121));

        load_const(X_UART, UART_TX_ADDR);
        load_const(5'd1, $urandom);
        load_const(5'd2, $urandom);
        load_const(5'd18, $urandom | 32'h8000_0000);  // negative operand for sra
        build_alu();
        build_forward_mem();
        build_branches();
        build_jumps();
        emit(enc_j(21'd0, 5'd0));  // self-loop

        foreach (prog[i]) begin
            @(posedge clk);
            prog_we   <= 1'b1;
            prog_addr <= i;
            prog_data <= prog[i];
        end
        @(posedge clk);
        prog_we <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;

        wait (chk_ready);
        fork
            begin
                wait (chk_done);
                repeat (20) @(posedge clk);  // room for a stray extra byte
            end
            begin
                repeat (chk_bound * 2 + 100) @(posedge clk);
                timed_out = 1'b1;
            end
        join_any
        disable fork;

        if (timed_out) begin
            $display("timeout: run did not finish within %0d cycles", chk_bound * 2 + 100);
        end
        if (chk_missing > 0) begin
            $display("missing %0d UART bytes at end of run", chk_missing);
        end
        $display("errors: mismatches=%0d extra=%0d missing=%0d timeout=%0d",
                 chk_mismatches, chk_extras, chk_missing, timed_out);
        if (chk_mismatches == 0 && chk_extras == 0 && chk_missing == 0 && !timed_out) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: rv_core.f
source/rv_pkg.sv
source/rv_fetch.sv
source/rv_decode.sv
source/rv_regfile.sv
source/rv_execute.sv
source/rv_dmem.sv
source/rv_core.sv
tb/rv_checker.sv
tb/tb_rv_core.sv
